//--- vlog.f
logic/mem_pkg.sv
logic/bus_pkg.sv
logic/dmem_bank.sv
logic/mem_stage.sv
logic/wb_bridge.sv
logic/io_regs.sv
logic/load_align.sv
logic/mem_subsystem.sv
test/mem_subsystem_checker.sv
test/mem_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb;

    localparam int DMEM_AW    = 10;
    localparam int IO_WAIT    = 2;
    localparam int N_FILL     = 64;  // Word stores over the local window
    localparam int N_LOCAL    = 400;
    localparam int N_MIXED    = 60;
    localparam int N_ACCESS   = N_FILL + N_LOCAL + N_MIXED + 20;
    localparam int MAX_CYCLES = 8 + N_ACCESS * (IO_WAIT + 3) + 100;

    localparam logic [31:0] LOCAL_BASE = 32'h0000_0800;
    localparam logic [31:0] IO_ADDR    = {bus_pkg::IO_BASE_HI, 12'h000};

    logic               clk;
    logic               rst_n;
    logic               mem_read;
    logic               mem_write;
    mem_pkg::mem_type_e mem_type;
    logic [31:0]        alu_out;
    logic [31:0]        store_data;
    logic [31:0]        fwd_data;
    logic               fwd_sel;
    logic               jal;
    logic               lui;
    logic [31:0]        imm;
    logic [31:0]        pc_inc;
    logic [31:0]        result;
    logic [31:0]        load_data;
    logic               load_valid;
    logic               stall;

    logic [31:0] rng;
    logic [7:0]  ref_mem [256];     // Local window, indexed by addr[7:0]
    logic [31:0] ref_scratch [3];
    logic [31:0] ref_count;         // Completed bus cycles
    logic        load_pending;
    logic [31:0] load_expect;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    mem_subsystem #(
        .DMEM_AW(DMEM_AW),
        .IO_WAIT(IO_WAIT)
    ) mem_subsystem_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .mem_type_i   (mem_type),
        .alu_out_i    (alu_out),
        .store_data_i (store_data),
        .fwd_data_i   (fwd_data),
        .fwd_sel_i    (fwd_sel),
        .jal_i        (jal),
        .lui_i        (lui),
        .imm_i        (imm),
        .pc_inc_i     (pc_inc),
        .result_o     (result),
        .load_data_o  (load_data),
        .load_valid_o (load_valid),
        .stall_o      (stall)
    );

    bind mem_subsystem mem_subsystem_checker #(
        .IO_WAIT(IO_WAIT)
    ) mem_subsystem_checker_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_sel_i     (wb_sel),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_m2s),
        .wb_ack_i     (wb_ack),
        .stall_i      (stall_o),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_type_i   (mem_type_i),
        .alu_out_i    (alu_out_i),
        .store_data_i (store_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Ends a hung run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    function automatic mem_pkg::mem_type_e pick_type(input logic [31:0] r);
        case (r % 32'd5)
            32'd0:   return mem_pkg::MEM_BYTE;
            32'd1:   return mem_pkg::MEM_UBYTE;
            32'd2:   return mem_pkg::MEM_HALF;
            32'd3:   return mem_pkg::MEM_UHALF;
            default: return mem_pkg::MEM_WORD;
        endcase
    endfunction

    function automatic int type_bytes(input mem_pkg::mem_type_e t);
        case (t)
            mem_pkg::MEM_WORD:                     return 4;
            mem_pkg::MEM_HALF, mem_pkg::MEM_UHALF: return 2;
            default:                               return 1;
        endcase
    endfunction

    function automatic logic is_io_addr(input logic [31:0] a);
        return a[31:12] == bus_pkg::IO_BASE_HI;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] a);
        if (!is_io_addr(a)) begin
            return ref_mem[a[7:0]];
        end else if (a[3:2] == 2'd3) begin
            return ref_count[8*a[1:0] +: 8];
        end else begin
            return ref_scratch[a[3:2]][8*a[1:0] +: 8];
        end
    endfunction

    // Little-endian bytes from the model, then extended per load type
    function automatic logic [31:0] expected_load(input mem_pkg::mem_type_e t,
                                                  input logic [31:0] a);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < type_bytes(t); i++) begin
            v[8*i +: 8] = model_byte(a + i);
        end
        case (t)
            mem_pkg::MEM_BYTE:  return {{24{v[7]}}, v[7:0]};
            mem_pkg::MEM_UBYTE: return {24'h000000, v[7:0]};
            mem_pkg::MEM_HALF:  return {{16{v[15]}}, v[15:0]};
            mem_pkg::MEM_UHALF: return {16'h0000, v[15:0]};
            default:            return v;
        endcase
    endfunction

    task automatic model_store(input mem_pkg::mem_type_e t, input logic [31:0] a,
                               input logic [31:0] w);
        logic [31:0] b;
        for (int i = 0; i < type_bytes(t); i++) begin
            b = a + i;
            if (!is_io_addr(b)) begin
                ref_mem[b[7:0]] = w[8*i +: 8];
            end else if (b[3:2] != 2'd3) begin
                ref_scratch[b[3:2]][8*b[1:0] +: 8] = w[8*i +: 8]; // IO_COUNT is read only
            end
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    endtask

    // Valid data exactly one cycle after a load, nothing otherwise
    task automatic check_load();
        checks++;
        if (load_pending) begin
            assert (load_valid === 1'b1 && load_data === load_expect)
                else report_mismatch("load_data_o", load_data, load_expect);
        end else begin
            assert (load_valid === 1'b0)
                else report_mismatch("load_valid_o", {31'd0, load_valid}, 32'd0);
        end
        load_pending = 1'b0;
    endtask

    task automatic run_access(input logic rd, input logic wr, input mem_pkg::mem_type_e t,
                              input logic [31:0] a, input logic [31:0] sdata,
                              input logic [31:0] fdata, input logic fsel);
        logic [31:0] r;
        logic [31:0] exp_result;
        logic [31:0] exp_load;
        logic        io;
        int          stalls;
        io       = is_io_addr(a) && (rd || wr);
        exp_load = expected_load(t, a);
        @(negedge clk);
        check_load();
        mem_read   = rd;
        mem_write  = wr;
        mem_type   = t;
        alu_out    = a;
        store_data = sdata;
        fwd_data   = fdata;
        fwd_sel    = fsel;
        draw_random(r);
        imm = {r[31:12], 12'h000};
        draw_random(r);
        pc_inc = {16'h0000, r[15:2], 2'b00};
        jal    = r[16];
        lui    = r[17];
        if (jal) begin
            exp_result = pc_inc;
        end else if (lui) begin
            exp_result = imm;
        end else begin
            exp_result = a;
        end
        stalls = 0;
        @(posedge clk);
        checks++;
        assert (result === exp_result) else report_mismatch("result_o", result, exp_result);
        while (stall) begin
            stalls++;
            @(posedge clk);
        end
        checks++;
        assert (stalls == (io ? IO_WAIT + 2 : 0))
            else report_mismatch("stall cycles", 32'(stalls), io ? 32'(IO_WAIT + 2) : 32'd0);
        if (wr) begin
            model_store(t, a, fsel ? fdata : sdata);
        end
        if (io) begin
            ref_count = ref_count + 1;
        end
        load_pending = rd;
        load_expect  = exp_load;
    endtask

    initial begin : stimulus
        logic [31:0]        r;
        logic [31:0]        a;
        logic [31:0]        d;
        mem_pkg::mem_type_e t;
        rng          = 32'd47111;
        rst_n        = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_type     = mem_pkg::MEM_WORD;
        alu_out      = '0;
        store_data   = '0;
        fwd_data     = '0;
        fwd_sel      = 1'b0;
        jal          = 1'b0;
        lui          = 1'b0;
        imm          = '0;
        pc_inc       = '0;
        load_pending = 1'b0;
        load_expect  = '0;
        ref_count    = '0;
        for (int i = 0; i < 3; i++) begin
            ref_scratch[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Fill so every later local load hits written bytes
        for (int i = 0; i < N_FILL; i++) begin
            draw_random(d);
            run_access(1'b0, 1'b1, mem_pkg::MEM_WORD, LOCAL_BASE + 4*i, d, ~d, 1'b0);
        end

        // Forwarded store data wins over store_data_i
        run_access(1'b0, 1'b1, mem_pkg::MEM_WORD, LOCAL_BASE + 32'h10, 32'h1111_1111,
                   32'hCAFE_F00D, 1'b1);
        run_access(1'b1, 1'b0, mem_pkg::MEM_WORD, LOCAL_BASE + 32'h10, '0, '0, 1'b0);
        run_access(1'b0, 1'b1, mem_pkg::MEM_BYTE, LOCAL_BASE + 32'h13, 32'h0000_0022,
                   32'h0000_0085, 1'b1);
        run_access(1'b1, 1'b0, mem_pkg::MEM_BYTE, LOCAL_BASE + 32'h13, '0, '0, 1'b0);

        // Back-to-back local traffic
        for (int i = 0; i < N_LOCAL; i++) begin
            draw_random(r);
            t = pick_type(r);
            a = (LOCAL_BASE | {24'h000000, r[15:8]}) & ~(type_bytes(t) - 1);
            draw_random(d);
            run_access(r[17:16] == 2'd1 || r[17:16] == 2'd2, r[17:16] == 2'd0, t, a, d,
                       {d[15:0], d[31:16]}, r[20]);
        end

        // I/O scratch words, byte write, signed and unsigned reads
        for (int k = 0; k < 3; k++) begin
            draw_random(d);
            run_access(1'b0, 1'b1, mem_pkg::MEM_WORD, IO_ADDR + 4*k, d, '0, 1'b0);
        end
        run_access(1'b0, 1'b1, mem_pkg::MEM_BYTE, IO_ADDR + 32'h6, 32'h0000_00A5, '0, 1'b0);
        run_access(1'b1, 1'b0, mem_pkg::MEM_BYTE, IO_ADDR + 32'h6, '0, '0, 1'b0);
        run_access(1'b1, 1'b0, mem_pkg::MEM_UBYTE, IO_ADDR + 32'h6, '0, '0, 1'b0);
        run_access(1'b1, 1'b0, mem_pkg::MEM_WORD, IO_ADDR + 32'h4, '0, '0, 1'b0);

        // Access counter, and a write to it that must not stick
        run_access(1'b1, 1'b0, mem_pkg::MEM_WORD, IO_ADDR + 32'hC, '0, '0, 1'b0);
        run_access(1'b0, 1'b1, mem_pkg::MEM_WORD, IO_ADDR + 32'hC, 32'hDEAD_BEEF, '0, 1'b0);
        run_access(1'b1, 1'b0, mem_pkg::MEM_WORD, IO_ADDR + 32'hC, '0, '0, 1'b0);

        // Local and I/O accesses mixed
        for (int i = 0; i < N_MIXED; i++) begin
            draw_random(r);
            t = pick_type(r);
            if (r[24]) begin
                a = IO_ADDR | {28'h0000000, r[3:0]};
            end else begin
                a = LOCAL_BASE | {24'h000000, r[15:8]};
            end
            a = a & ~(type_bytes(t) - 1);
            draw_random(d);
            run_access(!r[17], r[17], t, a, d, ~d, r[20]);
        end

        run_access(1'b0, 1'b0, mem_pkg::MEM_WORD, '0, '0, '0, 1'b0); // Drains the last load

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mem_subsystem_checker.sv
`default_nettype none

module mem_subsystem_checker #(
    parameter int IO_WAIT = 1
) (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         wb_cyc_i,
    input logic                         wb_stb_i,
    input logic                         wb_we_i,
    input logic [bus_pkg::WB_SEL_W-1:0] wb_sel_i,
    input logic [bus_pkg::WB_ADR_W-1:0] wb_adr_i,
    input logic [bus_pkg::WB_DAT_W-1:0] wb_dat_i,
    input logic                         wb_ack_i,
    input logic                         stall_i,
    input logic                         mem_read_i,
    input logic                         mem_write_i,
    input mem_pkg::mem_type_e           mem_type_i,
    input logic [mem_pkg::XLEN-1:0]     alu_out_i,
    input logic [mem_pkg::XLEN-1:0]     store_data_i
);

    int stall_run; // Stall cycles in a row before this one

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_run <= 0;
        end else if (stall_i) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_i |-> wb_cyc_i)
        else $error("Wishbone stb is high without cyc");

    // Master holds the whole cycle until ack
    a_master_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_i && !wb_ack_i |=>
            $stable({wb_cyc_i, wb_stb_i, wb_we_i, wb_sel_i, wb_adr_i, wb_dat_i}))
        else $error("Wishbone master outputs changed before ack");

    a_ack_in_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_i |-> wb_stb_i)
        else $error("Wishbone ack arrived outside a strobe");

    a_stall_len: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> stall_run < IO_WAIT + 2)
        else $error("Stall lasted longer than the I/O access allows");

    a_inputs_held: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable({mem_read_i, mem_write_i, mem_type_i, alu_out_i, store_data_i}))
        else $error("EX/MEM inputs changed while the stage was stalled");

endmodule

`default_nettype wire

//--- logic/mem_subsystem.sv
`default_nettype none

module mem_subsystem #(
    parameter int DMEM_AW = 10,
    parameter int IO_WAIT = 1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mem_read_i,
    input  logic                     mem_write_i,
    input  mem_pkg::mem_type_e       mem_type_i,
    input  logic [mem_pkg::XLEN-1:0] alu_out_i,
    input  logic [mem_pkg::XLEN-1:0] store_data_i,
    input  logic [mem_pkg::XLEN-1:0] fwd_data_i,
    input  logic                     fwd_sel_i,
    input  logic                     jal_i,
    input  logic                     lui_i,
    input  logic [mem_pkg::XLEN-1:0] imm_i,
    input  logic [mem_pkg::XLEN-1:0] pc_inc_i,
    output logic [mem_pkg::XLEN-1:0] result_o,
    output logic [mem_pkg::XLEN-1:0] load_data_o,
    output logic                     load_valid_o,
    output logic                     stall_o
);

    logic                         bus_req;
    logic                         bus_we;
    logic [bus_pkg::WB_SEL_W-1:0] bus_sel;
    logic [bus_pkg::WB_DAT_W-1:0] bus_wdata;
    logic [bus_pkg::WB_DAT_W-1:0] bus_rdata;
    logic                         bus_done;
    logic [mem_pkg::XLEN-1:0]     raw_rdata;

    // Wishbone link between bridge and register block
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [bus_pkg::WB_SEL_W-1:0] wb_sel;
    logic [bus_pkg::WB_ADR_W-1:0] wb_adr;
    logic [bus_pkg::WB_DAT_W-1:0] wb_dat_m2s;
    logic [bus_pkg::WB_DAT_W-1:0] wb_dat_s2m;
    logic                         wb_ack;

    mem_stage #(
        .DMEM_AW(DMEM_AW)
    ) mem_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_type_i   (mem_type_i),
        .alu_out_i    (alu_out_i),
        .store_data_i (store_data_i),
        .fwd_data_i   (fwd_data_i),
        .fwd_sel_i    (fwd_sel_i),
        .jal_i        (jal_i),
        .lui_i        (lui_i),
        .imm_i        (imm_i),
        .pc_inc_i     (pc_inc_i),
        .bus_rdata_i  (bus_rdata),
        .bus_done_i   (bus_done),
        .bus_req_o    (bus_req),
        .bus_we_o     (bus_we),
        .bus_sel_o    (bus_sel),
        .bus_wdata_o  (bus_wdata),
        .raw_rdata_o  (raw_rdata),
        .result_o     (result_o)
    );

    wb_bridge wb_bridge_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (bus_req),
        .we_i     (bus_we),
        .sel_i    (bus_sel),
        .adr_i    (alu_out_i),
        .wdata_i  (bus_wdata),
        .wb_ack_i (wb_ack),
        .wb_dat_i (wb_dat_s2m),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_sel_o (wb_sel),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_m2s),
        .rdata_o  (bus_rdata),
        .done_o   (bus_done),
        .stall_o  (stall_o)
    );

    io_regs #(
        .IO_WAIT(IO_WAIT)
    ) io_regs_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_sel_i (wb_sel),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_m2s),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_s2m)
    );

    load_align load_align_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept_i     (mem_read_i && !stall_o), // Load leaves the stage
        .mem_type_i   (mem_type_i),
        .offset_i     (alu_out_i[1:0]),
        .raw_i        (raw_rdata),
        .load_data_o  (load_data_o),
        .load_valid_o (load_valid_o)
    );

endmodule

`default_nettype wire

//--- logic/load_align.sv
`default_nettype none

module load_align (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     accept_i,
    input  mem_pkg::mem_type_e       mem_type_i,
    input  logic [1:0]               offset_i,
    input  logic [mem_pkg::XLEN-1:0] raw_i,
    output logic [mem_pkg::XLEN-1:0] load_data_o,
    output logic                     load_valid_o
);

    mem_pkg::mem_type_e       type_q;
    logic [1:0]               offset_q;
    logic [mem_pkg::XLEN-1:0] shifted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_valid_o <= 1'b0;
        end else begin
            load_valid_o <= accept_i; // Data follows one cycle after acceptance
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            type_q   <= mem_type_i;
            offset_q <= offset_i;
        end
    end

    assign shifted = raw_i >> {offset_q, 3'b000};

    // Sign or zero extension
    always_comb begin
        case (type_q)
            mem_pkg::MEM_BYTE:  load_data_o = {{24{shifted[7]}}, shifted[7:0]};
            mem_pkg::MEM_UBYTE: load_data_o = {24'h000000, shifted[7:0]};
            mem_pkg::MEM_HALF:  load_data_o = {{16{shifted[15]}}, shifted[15:0]};
            mem_pkg::MEM_UHALF: load_data_o = {16'h0000, shifted[15:0]};
            default:            load_data_o = raw_i;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/io_regs.sv
`default_nettype none

module io_regs #(
    parameter int IO_WAIT = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [bus_pkg::WB_SEL_W-1:0]  wb_sel_i,
    input  logic [bus_pkg::WB_ADR_W-1:0]  wb_adr_i,
    input  logic [bus_pkg::WB_DAT_W-1:0]  wb_dat_i,
    output logic                          wb_ack_o,
    output logic [bus_pkg::WB_DAT_W-1:0]  wb_dat_o
);

    localparam int CNT_W = (IO_WAIT > 0) ? $clog2(IO_WAIT + 1) : 1;

    logic [CNT_W-1:0]             wait_cnt;
    logic [bus_pkg::WB_DAT_W-1:0] scratch [3];
    logic [bus_pkg::WB_DAT_W-1:0] access_cnt;
    bus_pkg::io_reg_e             reg_idx;
    logic                         req;
    logic                         fire;

    assign reg_idx = bus_pkg::io_reg_e'(wb_adr_i[3:2]);
    assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign fire    = req && (wait_cnt == CNT_W'(IO_WAIT)); // Last wait state done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_o   <= 1'b0;
            wait_cnt   <= '0;
            access_cnt <= '0;
            for (int i = 0; i < 3; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            wb_ack_o <= fire;
            if (fire) begin
                wait_cnt <= '0;
            end else if (req) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (wb_ack_o) begin
                access_cnt <= access_cnt + 1'b1; // One more finished cycle
            end
            // Byte-lane writes, IO_COUNT ignores them
            for (int i = 0; i < 3; i++) begin
                for (int b = 0; b < bus_pkg::WB_SEL_W; b++) begin
                    if (fire && wb_we_i && reg_idx == bus_pkg::io_reg_e'(i) && wb_sel_i[b]) begin
                        scratch[i][8*b +: 8] <= wb_dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read data latched together with ack
    always_ff @(posedge clk) begin
        if (fire && !wb_we_i) begin
            case (reg_idx)
                bus_pkg::IO_SCRATCH0: wb_dat_o <= scratch[0];
                bus_pkg::IO_SCRATCH1: wb_dat_o <= scratch[1];
                bus_pkg::IO_SCRATCH2: wb_dat_o <= scratch[2];
                default:              wb_dat_o <= access_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/wb_bridge.sv
`default_nettype none

module wb_bridge (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [bus_pkg::WB_SEL_W-1:0]  sel_i,
    input  logic [bus_pkg::WB_ADR_W-1:0]  adr_i,
    input  logic [bus_pkg::WB_DAT_W-1:0]  wdata_i,
    input  logic                          wb_ack_i,
    input  logic [bus_pkg::WB_DAT_W-1:0]  wb_dat_i,
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output logic                          wb_we_o,
    output logic [bus_pkg::WB_SEL_W-1:0]  wb_sel_o,
    output logic [bus_pkg::WB_ADR_W-1:0]  wb_adr_o,
    output logic [bus_pkg::WB_DAT_W-1:0]  wb_dat_o,
    output logic [bus_pkg::WB_DAT_W-1:0]  rdata_o,
    output logic                          done_o,
    output logic                          stall_o
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e state;

    assign done_o  = (state == BUSY) && wb_ack_i;
    assign stall_o = req_i && !done_o; // Drops in the ack cycle so the access can retire

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
        end else if (state == IDLE && req_i) begin
            state    <= BUSY;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
        end else if (done_o) begin
            state    <= IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
        end
    end

    // Cycle payload, held until ack
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            wb_we_o  <= we_i;
            wb_sel_o <= sel_i;
            wb_adr_o <= adr_i;
            wb_dat_o <= wdata_i;
        end
        if (done_o && !wb_we_o) begin
            rdata_o <= wb_dat_i; // Read word for the writeback side
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`default_nettype none

module mem_stage #(
    parameter int DMEM_AW = 10
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              mem_read_i,
    input  logic                              mem_write_i,
    input  mem_pkg::mem_type_e                mem_type_i,
    input  logic [mem_pkg::XLEN-1:0]          alu_out_i,
    input  logic [mem_pkg::XLEN-1:0]          store_data_i,
    input  logic [mem_pkg::XLEN-1:0]          fwd_data_i,
    input  logic                              fwd_sel_i,
    input  logic                              jal_i,
    input  logic                              lui_i,
    input  logic [mem_pkg::XLEN-1:0]          imm_i,
    input  logic [mem_pkg::XLEN-1:0]          pc_inc_i,
    input  logic [mem_pkg::XLEN-1:0]          bus_rdata_i,
    input  logic                              bus_done_i,
    output logic                              bus_req_o,
    output logic                              bus_we_o,
    output logic [bus_pkg::WB_SEL_W-1:0]      bus_sel_o,
    output logic [mem_pkg::XLEN-1:0]          bus_wdata_o,
    output logic [mem_pkg::XLEN-1:0]          raw_rdata_o,
    output logic [mem_pkg::XLEN-1:0]          result_o
);

    logic [mem_pkg::XLEN-1:0]     write_data;
    logic [mem_pkg::XLEN-1:0]     lane_data;  // Store bytes replicated onto their lanes
    logic [mem_pkg::XLEN-1:0]     bank_word;
    logic [bus_pkg::WB_SEL_W-1:0] byte_en;
    logic [1:0]                   offset;
    logic                         is_io;
    logic                         last_io;

    assign write_data = fwd_sel_i ? fwd_data_i : store_data_i; // Writeback forwarding
    assign offset     = alu_out_i[1:0];
    assign is_io      = (alu_out_i[31:12] == bus_pkg::IO_BASE_HI);

    // Register result for JAL, LUI and ALU ops
    assign result_o = jal_i ? pc_inc_i : (lui_i ? imm_i : alu_out_i);

    // Byte enables and lane placement from access type and offset
    always_comb begin
        byte_en   = 4'b0000;
        lane_data = write_data;
        case (mem_type_i)
            mem_pkg::MEM_BYTE, mem_pkg::MEM_UBYTE: begin
                byte_en   = 4'b0001 << offset;
                lane_data = {4{write_data[7:0]}};
            end
            mem_pkg::MEM_HALF, mem_pkg::MEM_UHALF: begin
                byte_en   = offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{write_data[15:0]}};
            end
            mem_pkg::MEM_WORD: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    for (genvar i = 0; i < mem_pkg::BANK_CNT; i++) begin : g_bank
        dmem_bank #(
            .DMEM_AW(DMEM_AW)
        ) dmem_bank_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .addr_i  (alu_out_i[DMEM_AW+1:2]),
            .re_i    (mem_read_i && !is_io && byte_en[i]),
            .we_i    (mem_write_i && !is_io && byte_en[i]),
            .wdata_i (lane_data[8*i +: 8]),
            .rdata_o (bank_word[8*i +: 8])
        );
    end

    // I/O window goes to the Wishbone bridge
    assign bus_req_o   = (mem_read_i || mem_write_i) && is_io;
    assign bus_we_o    = mem_write_i;
    assign bus_sel_o   = byte_en;
    assign bus_wdata_o = lane_data;

    // Source of the raw word, updated when a load leaves the stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_io <= 1'b0;
        end else if (mem_read_i && (!is_io || bus_done_i)) begin
            last_io <= is_io;
        end
    end

    assign raw_rdata_o = last_io ? bus_rdata_i : bank_word;

endmodule

`default_nettype wire

//--- logic/dmem_bank.sv
`default_nettype none

module dmem_bank #(
    parameter int DMEM_AW = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [DMEM_AW-1:0] addr_i,
    input  logic               re_i,
    input  logic               we_i,
    input  logic [7:0]         wdata_i,
    output logic [7:0]         rdata_o
);

    localparam int DEPTH = 2 ** DMEM_AW;

    logic [7:0] mem [DEPTH];

    // Byte storage
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // Registered read port, holds the last byte read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_o <= 8'h00;
        end else if (re_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Upper address bits that select the I/O window
    localparam logic [19:0] IO_BASE_HI = 20'h40000;

    // Wishbone classic widths
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;

    // Register map of the I/O block, word index from adr[3:2]
    typedef enum logic [1:0] {
        IO_SCRATCH0 = 2'd0,
        IO_SCRATCH1 = 2'd1,
        IO_SCRATCH2 = 2'd2,
        IO_COUNT    = 2'd3  // Completed bus cycles, read only
    } io_reg_e;

endpackage

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Data path width of the pipeline and of one memory word
    localparam int XLEN = 32;

    // Bytes per memory word, one bank each
    localparam int BANK_CNT = XLEN / 8;

    // Access type of a load or store
    // Encoded like funct3 of the RV32I load and store opcodes
    typedef enum logic [2:0] {
        MEM_BYTE  = 3'b000, // LB and SB
        MEM_HALF  = 3'b001, // LH and SH
        MEM_WORD  = 3'b010, // LW and SW
        MEM_UBYTE = 3'b100, // LBU
        MEM_UHALF = 3'b101  // LHU
    } mem_type_e;

endpackage

`default_nettype wire
